/* common/fp24_pkg.sv */
// fp24 format, operation codes and sequencer states shared by the dot-product engine
`default_nettype none

package fp24_pkg;

  localparam int FP24_EXP_W  = 7;
  localparam int FP24_MANT_W = 16;
  // Mantissa plus the hidden leading one
  localparam int FP24_FRAC_W = FP24_MANT_W + 1;
  localparam int FP24_BIAS   = 63;

  typedef struct packed {
    logic                   sign;
    logic [FP24_EXP_W-1:0]  exp;
    logic [FP24_MANT_W-1:0] mant;
  } fp24;

  // Zero is all-zero exponent and mantissa
  localparam fp24 FP24_ZERO = '0;

  typedef enum logic [1:0] {
    OP_DOT     = 2'd0,
    OP_NEG_DOT = 2'd1,
    OP_SUM     = 2'd2
  } dot_op_t;

  typedef enum logic [2:0] {
    S_IDLE  = 3'd0,
    S_FETCH = 3'd1,
    S_MUL   = 3'd2,
    S_ADD   = 3'd3,
    S_DONE  = 3'd4
  } seq_state_t;

endpackage

`default_nettype wire

/* fp24/clz.sv */
// Count-leading-zeros, combinational priority search from the top bit
`default_nettype none

module clz #(
  parameter int WIDTH = 17
) (
  input wire [WIDTH-1:0] x,
  output logic [$clog2(WIDTH):0] count
);

  localparam int CNT_W = $clog2(WIDTH) + 1;

  // All zeros reports WIDTH
  always_comb begin
    count = CNT_W'(WIDTH);
    // Walk upward so the highest set bit wins
    for (int i = 0; i < WIDTH; i++) begin
      if (x[i]) begin
        count = CNT_W'(WIDTH - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

/* fp24/fp24_add.sv */
// fp24 adder and subtractor, two pipeline stages: align and add, then normalize
`default_nettype none

module fp24_add (
  input wire clk,
  input wire reset,
  input wire fp24_pkg::fp24 a,
  input wire fp24_pkg::fp24 b,
  input wire is_sub,
  output fp24_pkg::fp24 sum
);
  import fp24_pkg::*;

  localparam int SHIFT_W = $clog2(FP24_FRAC_W) + 1;

  logic a_larger;
  logic sign_b_eff;
  fp24 op_hi;
  fp24 op_lo;
  logic sign_hi;
  logic sign_lo;
  logic [FP24_EXP_W-1:0] exp_diff;
  logic [FP24_FRAC_W:0] frac_hi;
  logic [FP24_FRAC_W:0] frac_lo;
  logic [FP24_FRAC_W:0] frac_lo_shift;

  logic sign_q;
  logic [FP24_EXP_W-1:0] exp_q;
  logic [FP24_FRAC_W:0] frac_sum_q;
  logic both_zero_q;

  logic [SHIFT_W-1:0] shift;
  logic [FP24_FRAC_W-1:0] frac_norm;
  logic [FP24_EXP_W-1:0] exp_norm;

  // Stage 1: put the larger magnitude on the hi side and align the other
  always_comb begin
    a_larger = (a.exp > b.exp) || (a.exp == b.exp && a.mant > b.mant);
    sign_b_eff = b.sign ^ is_sub;
    if (a_larger) begin
      op_hi = a;
      op_lo = b;
      sign_hi = a.sign;
      sign_lo = sign_b_eff;
    end else begin
      op_hi = b;
      op_lo = a;
      sign_hi = sign_b_eff;
      sign_lo = a.sign;
    end
    // Hidden one only for nonzero exponents, so zero carries no fraction
    frac_hi = {1'b0, |op_hi.exp, op_hi.mant};
    frac_lo = {1'b0, |op_lo.exp, op_lo.mant};
    exp_diff = op_hi.exp - op_lo.exp;
    frac_lo_shift = frac_lo >> exp_diff;
  end

  always_ff @(posedge clk) begin
    if (sign_hi == sign_lo) begin
      frac_sum_q <= frac_hi + frac_lo_shift;
    end else begin
      frac_sum_q <= frac_hi - frac_lo_shift;
    end
    exp_q <= op_hi.exp;
    sign_q <= sign_hi;
  end

  // Output settles to zero after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      both_zero_q <= 1'b1;
    end else begin
      both_zero_q <= (frac_hi == '0) && (frac_lo == '0);
    end
  end

  // Stage 2: normalize on carry-out or leading zeros
  clz #(.WIDTH(FP24_FRAC_W)) clz0 (
    .x(frac_sum_q[FP24_FRAC_W-1:0]),
    .count(shift)
  );

  always_comb begin
    if (frac_sum_q[FP24_FRAC_W]) begin
      frac_norm = frac_sum_q[FP24_FRAC_W:1];
      exp_norm = exp_q + 1'b1;
    end else begin
      frac_norm = frac_sum_q[FP24_FRAC_W-1:0] << shift;
      exp_norm = exp_q - FP24_EXP_W'(shift);
    end
  end

  // Exact cancellation also lands on zero
  always_ff @(posedge clk) begin
    if (both_zero_q || frac_sum_q == '0) begin
      sum <= FP24_ZERO;
    end else begin
      sum <= {sign_q, exp_norm, frac_norm[FP24_MANT_W-1:0]};
    end
  end

endmodule

`default_nettype wire

/* fp24/fp24_mul.sv */
// fp24 multiplier, two pipeline stages: fraction product, then normalize and truncate
`default_nettype none

module fp24_mul (
  input wire clk,
  input wire reset,
  input wire fp24_pkg::fp24 a,
  input wire fp24_pkg::fp24 b,
  output fp24_pkg::fp24 product
);
  import fp24_pkg::*;

  localparam int PROD_W = 2 * FP24_FRAC_W;

  logic a_zero;
  logic b_zero;
  logic [PROD_W-1:0] prod_q;
  logic [FP24_EXP_W:0] exp_q;
  logic sign_q;
  logic zero_q;
  logic [FP24_MANT_W-1:0] mant_norm;
  logic [FP24_EXP_W-1:0] exp_norm;

  assign a_zero = (a.exp == FP24_ZERO.exp) && (a.mant == FP24_ZERO.mant);
  assign b_zero = (b.exp == FP24_ZERO.exp) && (b.mant == FP24_ZERO.mant);

  // Stage 1: fractions with hidden ones, one bias removed from the exponent sum
  always_ff @(posedge clk) begin
    prod_q <= {1'b1, a.mant} * {1'b1, b.mant};
    exp_q <= {1'b0, a.exp} + {1'b0, b.exp} - (FP24_EXP_W + 1)'(FP24_BIAS);
    sign_q <= a.sign ^ b.sign;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      zero_q <= 1'b1;
    end else begin
      zero_q <= a_zero || b_zero;
    end
  end

  // Stage 2: product of two [1,2) fractions lies in [1,4)
  always_comb begin
    if (prod_q[PROD_W-1]) begin
      mant_norm = prod_q[PROD_W-2 -: FP24_MANT_W];
      exp_norm = exp_q[FP24_EXP_W-1:0] + 1'b1;
    end else begin
      mant_norm = prod_q[PROD_W-3 -: FP24_MANT_W];
      exp_norm = exp_q[FP24_EXP_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (zero_q) begin
      product <= FP24_ZERO;
    end else begin
      product <= {sign_q, exp_norm, mant_norm};
    end
  end

endmodule

`default_nettype wire

/* source/operand_buffer.sv */
// Operand buffer holding a and b pairs, synchronous write and registered read
`default_nettype none

module operand_buffer #(
  parameter int DEPTH = 16,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input wire clk,
  input wire wr_en,
  input wire [ADDR_W-1:0] wr_addr,
  input wire fp24_pkg::fp24 wr_a,
  input wire fp24_pkg::fp24 wr_b,
  input wire [ADDR_W-1:0] rd_addr,
  output fp24_pkg::fp24 rd_a,
  output fp24_pkg::fp24 rd_b
);
  import fp24_pkg::*;

  fp24 mem_a [DEPTH];
  fp24 mem_b [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_a[wr_addr] <= wr_a;
      mem_b[wr_addr] <= wr_b;
    end
  end

  // Data shows up the cycle after the address
  always_ff @(posedge clk) begin
    rd_a <= mem_a[rd_addr];
    rd_b <= mem_b[rd_addr];
  end

endmodule

`default_nettype wire

/* source/op_counter.sv */
// Element index counter with a small countdown for arithmetic latency
`default_nettype none

module op_counter #(
  parameter int DEPTH = 16,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire load,
  input wire [ADDR_W:0] length,
  input wire step,
  input wire wait_load,
  input wire [1:0] wait_count,
  output logic [ADDR_W-1:0] index,
  output logic last,
  output logic wait_done
);

  logic [ADDR_W:0] len_q;
  logic [1:0] timer;

  always_ff @(posedge clk) begin
    if (reset) begin
      index <= '0;
      len_q <= '0;
    end else if (load) begin
      index <= '0;
      len_q <= length;
    end else if (step) begin
      index <= index + 1'b1;
    end
  end

  // Never matches when length is zero
  assign last = ({1'b0, index} == len_q - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      timer <= '0;
    end else if (wait_load) begin
      timer <= wait_count;
    end else if (timer != '0) begin
      timer <= timer - 1'b1;
    end
  end

  assign wait_done = (timer == '0);

endmodule

`default_nettype wire

/* source/dot_sequencer.sv */
// Dot-product sequencer FSM, fetches elements, waits out latency, updates accumulator
`default_nettype none

module dot_sequencer #(
  parameter int DEPTH = 16,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire start,
  input wire [ADDR_W:0] length,
  input wire fp24_pkg::dot_op_t op,
  output logic busy,
  output logic done,
  output fp24_pkg::fp24 result,
  output logic [ADDR_W-1:0] rd_addr,
  input wire fp24_pkg::fp24 rd_a,
  input wire fp24_pkg::fp24 rd_b,
  output fp24_pkg::fp24 mul_a,
  output fp24_pkg::fp24 mul_b,
  input wire fp24_pkg::fp24 mul_product,
  input wire fp24_pkg::fp24 add_sum,
  output fp24_pkg::fp24 add_a,
  output fp24_pkg::fp24 add_b,
  output logic add_is_sub,
  output logic cnt_load,
  output logic cnt_step,
  output logic wait_load,
  output logic [1:0] wait_count,
  input wire [ADDR_W-1:0] index,
  input wire last,
  input wire wait_done
);
  import fp24_pkg::*;

  // Two cycles in each of S_MUL and S_ADD
  localparam logic [1:0] STAGE_WAIT = 2'd1;

  seq_state_t state;
  seq_state_t state_next;
  dot_op_t op_q;
  fp24 acc;

  always_comb begin
    state_next = state;
    cnt_load = 1'b0;
    cnt_step = 1'b0;
    wait_load = 1'b0;
    wait_count = STAGE_WAIT;
    case (state)
      S_IDLE: begin
        if (start) begin
          cnt_load = 1'b1;
          state_next = (length == '0) ? S_DONE : S_FETCH;
        end
      end
      S_FETCH: begin
        wait_load = 1'b1;
        // OP_SUM has no product to wait for
        if (op_q == OP_SUM) begin
          state_next = S_ADD;
        end else begin
          state_next = S_MUL;
        end
      end
      S_MUL: begin
        if (wait_done) begin
          wait_load = 1'b1;
          state_next = S_ADD;
        end
      end
      S_ADD: begin
        if (wait_done) begin
          cnt_step = 1'b1;
          state_next = last ? S_DONE : S_FETCH;
        end
      end
      S_DONE: state_next = S_IDLE;
      default: state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= S_IDLE;
      op_q <= OP_DOT;
      acc <= FP24_ZERO;
      result <= FP24_ZERO;
    end else begin
      state <= state_next;
      if (cnt_load) begin
        op_q <= op;
        acc <= FP24_ZERO;
      end
      if (cnt_step) begin
        acc <= add_sum;
      end
      // Empty runs finish straight from idle with zero
      if (state_next == S_DONE) begin
        result <= (state == S_ADD) ? add_sum : FP24_ZERO;
      end
    end
  end

  // First element is read while start is taken, later ones during the final add cycle
  always_comb begin
    if (state == S_IDLE) begin
      rd_addr = '0;
    end else if (cnt_step) begin
      rd_addr = index + 1'b1;
    end else begin
      rd_addr = index;
    end
  end

  assign mul_a = rd_a;
  assign mul_b = rd_b;

  // Adder samples the product in the last S_MUL cycle, or rd_a in S_FETCH for OP_SUM
  assign add_a = acc;
  assign add_b = (op_q == OP_SUM) ? rd_a : mul_product;
  assign add_is_sub = (op_q == OP_NEG_DOT);

  assign busy = (state == S_FETCH) || (state == S_MUL) || (state == S_ADD);
  assign done = (state == S_DONE);

endmodule

`default_nettype wire

/* source/dot_engine.sv */
// fp24 dot-product engine top level, buffer, counter, sequencer and arithmetic units
`default_nettype none

module dot_engine #(
  parameter int DEPTH = 16,
  localparam int ADDR_W = $clog2(DEPTH)
) (
  input wire clk,
  input wire reset,
  input wire wr_en,
  input wire [ADDR_W-1:0] wr_addr,
  input wire fp24_pkg::fp24 wr_a,
  input wire fp24_pkg::fp24 wr_b,
  input wire start,
  input wire [ADDR_W:0] length,
  input wire fp24_pkg::dot_op_t op,
  output logic busy,
  output logic done,
  output fp24_pkg::fp24 result
);
  import fp24_pkg::*;

  logic [ADDR_W-1:0] rd_addr;
  fp24 rd_a;
  fp24 rd_b;
  fp24 mul_a;
  fp24 mul_b;
  fp24 mul_product;
  fp24 add_a;
  fp24 add_b;
  fp24 add_sum;
  logic add_is_sub;
  logic cnt_load;
  logic cnt_step;
  logic wait_load;
  logic [1:0] wait_count;
  logic [ADDR_W-1:0] index;
  logic last;
  logic wait_done;

  operand_buffer #(.DEPTH(DEPTH)) buffer0 (
    .clk(clk),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_a(wr_a),
    .wr_b(wr_b),
    .rd_addr(rd_addr),
    .rd_a(rd_a),
    .rd_b(rd_b)
  );

  op_counter #(.DEPTH(DEPTH)) counter0 (
    .clk(clk),
    .reset(reset),
    .load(cnt_load),
    .length(length),
    .step(cnt_step),
    .wait_load(wait_load),
    .wait_count(wait_count),
    .index(index),
    .last(last),
    .wait_done(wait_done)
  );

  dot_sequencer #(.DEPTH(DEPTH)) seq0 (
    .clk(clk),
    .reset(reset),
    .start(start),
    .length(length),
    .op(op),
    .busy(busy),
    .done(done),
    .result(result),
    .rd_addr(rd_addr),
    .rd_a(rd_a),
    .rd_b(rd_b),
    .mul_a(mul_a),
    .mul_b(mul_b),
    .mul_product(mul_product),
    .add_sum(add_sum),
    .add_a(add_a),
    .add_b(add_b),
    .add_is_sub(add_is_sub),
    .cnt_load(cnt_load),
    .cnt_step(cnt_step),
    .wait_load(wait_load),
    .wait_count(wait_count),
    .index(index),
    .last(last),
    .wait_done(wait_done)
  );

  fp24_mul mul0 (
    .clk(clk),
    .reset(reset),
    .a(mul_a),
    .b(mul_b),
    .product(mul_product)
  );

  fp24_add add0 (
    .clk(clk),
    .reset(reset),
    .a(add_a),
    .b(add_b),
    .is_sub(add_is_sub),
    .sum(add_sum)
  );

endmodule

`default_nettype wire

/* tests/dot_engine_properties.sv */
// Concurrent checks on the dot sequencer's busy, done and state outputs
`default_nettype none

module dot_engine_properties (
  input wire clk,
  input wire reset,
  input wire busy,
  input wire done,
  input wire fp24_pkg::seq_state_t state
);
  timeunit 1ns;
  timeprecision 100ps;

  import fp24_pkg::*;

  busy_done_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(busy && done))
    else $error("busy and done high in the same cycle");

  // Done is a single-cycle strobe
  done_single_cycle: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("done held for more than one cycle");

  idle_after_reset: assert property (@(posedge clk)
    reset |=> !busy && !done)
    else $error("busy or done high in the cycle after reset");

  idle_after_done: assert property (@(posedge clk) disable iff (reset)
    state == S_DONE |=> state == S_IDLE)
    else $error("state did not return to idle after done");

endmodule

bind dot_sequencer dot_engine_properties props0 (
  .clk(clk),
  .reset(reset),
  .busy(busy),
  .done(done),
  .state(state)
);

`default_nettype wire

/* tests/dot_engine_tb.sv */
// Directed testbench for the fp24 dot-product engine
`default_nettype none

module dot_engine_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import fp24_pkg::*;

  localparam int DEPTH = 16;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int TIMEOUT = 200;

  logic clk;
  logic reset;
  logic wr_en;
  logic [ADDR_W-1:0] wr_addr;
  fp24 wr_a;
  fp24 wr_b;
  logic start;
  logic [ADDR_W:0] length;
  dot_op_t op;
  logic busy;
  logic done;
  fp24 result;

  int seed = 2067;
  int error_count = 0;
  int checks_run = 0;
  int done_count = 0;
  // Second pair cancels the first, the last one brings the sum back to 6
  int dot_a [6] = '{3, -2, 5, 4, -1, 6};
  int dot_b [6] = '{2, 3, -1, -3, 7, 5};

  dot_engine #(.DEPTH(DEPTH)) dut0 (
    .clk(clk),
    .reset(reset),
    .wr_en(wr_en),
    .wr_addr(wr_addr),
    .wr_a(wr_a),
    .wr_b(wr_b),
    .start(start),
    .length(length),
    .op(op),
    .busy(busy),
    .done(done),
    .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Done pulses counted on the falling edge
  always @(negedge clk) begin
    if (done) begin
      done_count++;
    end
  end

  function automatic fp24 int_to_fp24(input int value);
    fp24 f;
    int mag;
    int top;
    f = FP24_ZERO;
    if (value != 0) begin
      mag = (value < 0) ? -value : value;
      top = 0;
      for (int i = 0; i < 17; i++) begin
        if (mag[i]) begin
          top = i;
        end
      end
      f.sign = (value < 0);
      f.exp = FP24_EXP_W'(FP24_BIAS + top);
      // Leading one becomes the hidden bit and drops out
      f.mant = FP24_MANT_W'(mag << (FP24_MANT_W - top));
    end
    return f;
  endfunction

  function automatic fp24 pow2_to_fp24(input int power);
    fp24 f;
    f = FP24_ZERO;
    f.exp = FP24_EXP_W'(FP24_BIAS + power);
    return f;
  endfunction

  task automatic check_fp24(input string name, input fp24 expected, input fp24 actual);
    checks_run++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks_run++;
    if (actual !== expected) begin
      error_count++;
      $display("Error: %s expected %b actual %b", name, expected, actual);
    end
  endtask

  task automatic check_pulses(input string name, input int expected, input int actual);
    checks_run++;
    if (actual != expected) begin
      error_count++;
      $display("Error: %s expected %0d actual %0d", name, expected, actual);
    end
  endtask

  task automatic write_pair(input int addr, input fp24 a, input fp24 b);
    @(posedge clk);
    #1;
    wr_en = 1'b1;
    wr_addr = ADDR_W'(addr);
    wr_a = a;
    wr_b = b;
    @(posedge clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic pulse_start(input dot_op_t o, input int len);
    @(posedge clk);
    #1;
    start = 1'b1;
    length = (ADDR_W + 1)'(len);
    op = o;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // Polls busy or done on the falling edge, bounded by TIMEOUT
  task automatic wait_for_signal(input string name, input bit on_done, output bit seen);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (((on_done ? done : busy) !== 1'b1) && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    seen = ((on_done ? done : busy) === 1'b1);
    if (!seen) begin
      error_count++;
      $display("%s: timed out waiting for %s", name, on_done ? "done" : "busy");
    end
  endtask

  task automatic run_op(input string name, input dot_op_t o, input int len,
                        input fp24 expected, input bit restart);
    int first_done;
    bit seen;
    first_done = done_count;
    pulse_start(o, len);
    if (restart) begin
      // Second start lands mid-run and must be ignored
      wait_for_signal(name, 1'b0, seen);
      pulse_start(OP_SUM, 1);
    end
    wait_for_signal(name, 1'b1, seen);
    if (seen) begin
      check_bit({name, " busy at done"}, 1'b0, busy);
      check_fp24(name, expected, result);
      @(negedge clk);
      check_bit({name, " done after pulse"}, 1'b0, done);
      check_fp24({name, " held"}, expected, result);
    end
    check_pulses({name, " done pulses"}, 1, done_count - first_done);
  endtask

  task automatic load_dot_data(output int total);
    total = 0;
    for (int i = 0; i < 6; i++) begin
      total += dot_a[i] * dot_b[i];
      write_pair(i, int_to_fp24(dot_a[i]), int_to_fp24(dot_b[i]));
    end
  endtask

  task automatic test_reset();
    @(negedge clk);
    check_bit("reset busy", 1'b0, busy);
    check_bit("reset done", 1'b0, done);
    check_fp24("reset result", FP24_ZERO, result);
  endtask

  task automatic test_sum();
    int total;
    int val;
    total = 0;
    for (int i = 0; i < 8; i++) begin
      val = $random(seed) % 21;
      total += val;
      write_pair(i, int_to_fp24(val), int_to_fp24(i + 1));
    end
    run_op("op_sum", OP_SUM, 8, int_to_fp24(total), 1'b0);
  endtask

  task automatic test_dot();
    int total;
    // 12 - 12 ends in exact zero
    write_pair(0, int_to_fp24(4), int_to_fp24(3));
    write_pair(1, int_to_fp24(-6), int_to_fp24(2));
    run_op("op_dot_cancel", OP_DOT, 2, FP24_ZERO, 1'b0);
    load_dot_data(total);
    run_op("op_dot", OP_DOT, 6, int_to_fp24(total), 1'b0);
  endtask

  task automatic test_neg_dot();
    int total;
    load_dot_data(total);
    run_op("op_neg_dot", OP_NEG_DOT, 6, int_to_fp24(-total), 1'b0);
    write_pair(0, pow2_to_fp24(-1), int_to_fp24(4));
    run_op("neg_half_times_four", OP_NEG_DOT, 1, int_to_fp24(-2), 1'b0);
    run_op("half_times_four", OP_DOT, 1, int_to_fp24(2), 1'b0);
  endtask

  task automatic test_control();
    int total;
    run_op("length_zero", OP_DOT, 0, FP24_ZERO, 1'b0);
    load_dot_data(total);
    run_op("start_while_busy", OP_DOT, 6, int_to_fp24(total), 1'b1);
  endtask

  initial begin
    reset = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_a = FP24_ZERO;
    wr_b = FP24_ZERO;
    start = 1'b0;
    length = '0;
    op = OP_DOT;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset();
    test_sum();
    test_dot();
    test_neg_dot();
    test_control();

    $display("Checks run: %0d, errors: %0d", checks_run, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
common/fp24_pkg.sv
fp24/clz.sv
fp24/fp24_add.sv
fp24/fp24_mul.sv
source/operand_buffer.sv
source/op_counter.sv
source/dot_sequencer.sv
source/dot_engine.sv
tests/dot_engine_properties.sv
tests/dot_engine_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = dot_engine_tb
FILELIST = project.f
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
